// File: project.f
+incdir+.
rast_fixed_pkg.sv
rast_prim_pkg.sv
bbox_extent.sv
bbox_grid_clip.sv
bbox_delay.sv
bbox_top.sv
tb_bbox.sv

// File: run.sh
#!/bin/sh
# Build the bounding box testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_bbox -f project.f -o tb_bbox \
    > build.log 2>&1 \
    && ./obj_dir/tb_bbox > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1

// File: tb_bbox_vectors.svh
// One row holds the triangle, tri_valid, screen, subsample and hold
// and then the expected box, triangle and valid
typedef struct packed {
    tri_t       tri_data;
    logic       tri_valid;
    point_t     screen;
    subsample_t subsample;
    logic       hold;
    box_t       exp_box;
    tri_t       exp_tri;
    logic       exp_valid;
} vec_row_t;

// Every row that the main loop applies, one per clock
vec_row_t vectors[$];

// Point from x and y in 1/32 pixel, one such unit is 32 LSBs
// Coordinates in the rows below are all given in these units
function automatic point_t pt(int x32, int y32);
    point_t p;
    p.x = coord_t'(x32 * 32);
    p.y = coord_t'(y32 * 32);
    return p;
endfunction

function automatic tri_t tri3(point_t a, point_t b, point_t c);
    tri_t t;
    t[0] = a;
    t[1] = b;
    t[2] = c;
    return t;
endfunction

// Append one row on the fixed test screen
// The expected triangle is always the one that went in
task automatic add_row(tri_t t, logic tv, subsample_t ss, logic hd,
                       point_t ll, point_t ur, logic ev);
    vec_row_t r;
    r.tri_data  = t;
    r.tri_valid = tv;
    r.screen.x  = SCREEN_X;
    r.screen.y  = SCREEN_Y;
    r.subsample = ss;
    r.hold      = hd;
    r.exp_box   = '{ll: ll, ur: ur};
    r.exp_tri   = t;
    r.exp_valid = ev;
    vectors.push_back(r);
endtask

task automatic load_vectors();
    tri_t t_base;
    tri_t t_perm1;
    tri_t t_perm2;
    tri_t t_tie;
    tri_t t_fine;
    tri_t t_origin;
    tri_t t_edge;
    tri_t t_left;
    tri_t t_below;
    tri_t t_right;
    tri_t t_above;
    tri_t t_touch;
    t_base   = tri3(pt(10*32+5, 20*32+3), pt(30*32+21, 5*32+1), pt(15*32+31, 40*32+2));
    t_perm1  = tri3(t_base[2], t_base[0], t_base[1]);
    t_perm2  = tri3(t_base[1], t_base[2], t_base[0]);
    t_tie    = tri3(pt(50*32+20, 60*32+20), pt(50*32+20, 62*32), pt(70*32, 60*32+20));
    t_fine   = tri3(pt(100*32+31, 200*32+27), pt(120*32+15, 210*32+29),
                    pt(110*32+3, 205*32+1));
    t_origin = tri3(pt(-5*32-3, 10*32), pt(20*32, -2*32-9), pt(30*32+1, 40*32));
    t_edge   = tri3(pt(630*32, 470*32), pt(650*32+3, 475*32), pt(635*32, 490*32+5));
    t_left   = tri3(pt(-30*32, 10*32), pt(-10*32-4, 20*32), pt(-20*32, 30*32));
    t_below  = tri3(pt(10*32, -30*32), pt(20*32, -5*32), pt(30*32, -20*32));
    t_right  = tri3(pt(700*32, 10*32), pt(720*32, 20*32), pt(710*32, 30*32));
    t_above  = tri3(pt(10*32, 500*32), pt(20*32, 520*32), pt(30*32, 510*32));
    t_touch  = tri3(pt(640*32+3, 10*32), pt(650*32, 20*32), pt(645*32, 30*32));

    // Extents in three vertex orders plus ties under the whole-pixel grid
    add_row(t_base, 1'b1, 4'b1000, 1'b0, pt(10*32, 5*32), pt(30*32, 40*32), 1'b1);
    add_row(t_perm1, 1'b1, 4'b1000, 1'b0, pt(10*32, 5*32), pt(30*32, 40*32), 1'b1);
    add_row(t_perm2, 1'b1, 4'b1000, 1'b0, pt(10*32, 5*32), pt(30*32, 40*32), 1'b1);
    add_row(t_tie, 1'b1, 4'b1000, 1'b0, pt(50*32, 60*32), pt(70*32, 62*32), 1'b1);

    // One triangle under every sample grid with the step halving each time
    add_row(t_fine, 1'b1, 4'b1000, 1'b0, pt(100*32, 200*32), pt(120*32, 210*32), 1'b1);
    add_row(t_fine, 1'b1, 4'b0100, 1'b0, pt(100*32+16, 200*32+16), pt(120*32, 210*32+16), 1'b1);
    add_row(t_fine, 1'b1, 4'b0010, 1'b0, pt(100*32+24, 200*32+24), pt(120*32+8, 210*32+24), 1'b1);
    add_row(t_fine, 1'b1, 4'b0001, 1'b0, pt(100*32+28, 200*32+24), pt(120*32+12, 210*32+28), 1'b1);

    // Clamping at the origin and the far screen edges
    add_row(t_origin, 1'b1, 4'b1000, 1'b0, pt(0, 0), pt(30*32, 40*32), 1'b1);
    add_row(t_edge, 1'b1, 4'b1000, 1'b0, pt(630*32, 470*32), pt(640*32, 480*32), 1'b1);
    add_row(t_touch, 1'b1, 4'b1000, 1'b0, pt(640*32, 10*32), pt(640*32, 30*32), 1'b1);

    // Wholly off screen on each side and then an invalid input
    add_row(t_left, 1'b1, 4'b1000, 1'b0, pt(0, 10*32), pt(-11*32, 30*32), 1'b0);
    add_row(t_below, 1'b1, 4'b1000, 1'b0, pt(10*32, 0), pt(30*32, -5*32), 1'b0);
    add_row(t_right, 1'b1, 4'b1000, 1'b0, pt(700*32, 10*32), pt(640*32, 30*32), 1'b0);
    add_row(t_above, 1'b1, 4'b1000, 1'b0, pt(10*32, 500*32), pt(30*32, 480*32), 1'b0);
    add_row(t_base, 1'b0, 4'b1000, 1'b0, pt(10*32, 5*32), pt(30*32, 40*32), 1'b0);

    // Three items back to back and a stall with a valid triangle waiting
    add_row(t_base, 1'b1, 4'b1000, 1'b0, pt(10*32, 5*32), pt(30*32, 40*32), 1'b1);
    add_row(t_fine, 1'b1, 4'b0001, 1'b0, pt(100*32+28, 200*32+24), pt(120*32+12, 210*32+28), 1'b1);
    add_row(t_origin, 1'b1, 4'b1000, 1'b0, pt(0, 0), pt(30*32, 40*32), 1'b1);
    for (int n = 0; n < 5; n++) begin
        add_row(t_edge, 1'b1, 4'b1000, 1'b1, pt(0, 0), pt(0, 0), 1'b0);
    end
    add_row(t_tie, 1'b1, 4'b1000, 1'b0, pt(50*32, 60*32), pt(70*32, 62*32), 1'b1);
endtask

// File: tb_bbox.sv
`timescale 1ns/1ps

module tb_bbox
    import rast_fixed_pkg::*;
    import rast_prim_pkg::*;
();

    localparam int PIPE_DEPTH   = 3;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_ROWS  = 200;
    // Test screen of 640 by 480 pixels
    localparam coord_t SCREEN_X = coord_t'(640 << RADIX);
    localparam coord_t SCREEN_Y = coord_t'(480 << RADIX);
    // Random centres reach 64 pixels past every screen side
    localparam int MARGIN = 64 << RADIX;
    // Vertices lie within 32 pixels of their centre
    localparam int SPREAD = 32 << RADIX;

    logic       clk = 1'b0;
    logic       reset;
    tri_t       tri_in;
    logic       tri_valid;
    point_t     screen;
    subsample_t subsample;
    logic       hold;
    tri_t       tri_out;
    box_t       box_out;
    logic       box_valid;

    // One item still on its way through the pipeline
    typedef struct packed {
        int   idx;
        tri_t t;
        box_t b;
        logic v;
    } exp_entry_t;

    exp_entry_t  exp_q[$];
    exp_entry_t  last_out;
    logic        have_last;
    logic        rows_ready;
    logic [31:0] lcg_state;
    int          err_count;
    int          pass_count;
    int          fail_count;

    `include "tb_bbox_vectors.svh"

    always #5 clk = ~clk;

    bbox_top #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .screen    (screen),
        .subsample (subsample),
        .hold      (hold),
        .tri_out   (tri_out),
        .box_out   (box_out),
        .box_valid (box_valid)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Centre anywhere from MARGIN before the origin to MARGIN past span
    function automatic coord_t rand_coord(coord_t span);
        logic [31:0] r;
        int range;
        r = lcg_next();
        range = int'(span) + 2 * MARGIN;
        return coord_t'(int'((r >> 7) % range) - MARGIN);
    endfunction

    function automatic coord_t rand_offset();
        logic [31:0] r;
        r = lcg_next();
        return coord_t'(int'((r >> 7) % (2 * SPREAD)) - SPREAD);
    endfunction

    // Round toward minus infinity onto a grid of 2**sh LSBs
    function automatic coord_t floor_to(coord_t c, int sh);
        return (c >>> sh) <<< sh;
    endfunction

    // Expected box and valid straight from the extent, floor and clip rules
    task automatic model_item(input tri_t t, input logic tv, input point_t scr,
                              input subsample_t ss, output box_t b, output logic v);
        coord_t lo_x;
        coord_t hi_x;
        coord_t lo_y;
        coord_t hi_y;
        int sh;
        lo_x = t[0].x;
        hi_x = t[0].x;
        lo_y = t[0].y;
        hi_y = t[0].y;
        for (int k = 1; k < VERTS; k++) begin
            if (t[k].x < lo_x) lo_x = t[k].x;
            if (t[k].x > hi_x) hi_x = t[k].x;
            if (t[k].y < lo_y) lo_y = t[k].y;
            if (t[k].y > hi_y) hi_y = t[k].y;
        end
        // Code bit j selects a grid of 2**(RADIX-3+j) LSBs
        // 1000 is one whole pixel and 0001 an eighth
        sh = RADIX;
        for (int j = 0; j < 4; j++) begin
            if (ss[j]) sh = RADIX - 3 + j;
        end
        b.ll.x = floor_to(lo_x, sh);
        b.ll.y = floor_to(lo_y, sh);
        b.ur.x = floor_to(hi_x, sh);
        b.ur.y = floor_to(hi_y, sh);
        if (b.ll.x < 0) b.ll.x = '0;
        if (b.ll.y < 0) b.ll.y = '0;
        if (b.ur.x > scr.x) b.ur.x = scr.x;
        if (b.ur.y > scr.y) b.ur.y = scr.y;
        v = tv && (b.ll.x <= scr.x) && (b.ll.y <= scr.y) && (b.ur.x >= 0) && (b.ur.y >= 0);
    endtask

    task automatic check_box(input string name, input box_t got, input box_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_tri(input string name, input tri_t got, input tri_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_row(input int idx, input string what, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("row %0d %s ok", idx, what);
        end else begin
            fail_count++;
            $display("row %0d %s FAIL", idx, what);
        end
    endtask

    task automatic add_random_rows(input int count);
        vec_row_t r;
        coord_t base_x;
        coord_t base_y;
        logic [31:0] rnd;
        for (int n = 0; n < count; n++) begin
            base_x = rand_coord(SCREEN_X);
            base_y = rand_coord(SCREEN_Y);
            for (int k = 0; k < VERTS; k++) begin
                r.tri_data[k].x = base_x + rand_offset();
                r.tri_data[k].y = base_y + rand_offset();
            end
            rnd = lcg_next();
            r.tri_valid = (rnd[22:20] != 3'b000);
            r.subsample = subsample_t'(4'b0001 << rnd[25:24]);
            // About one stall cycle in four
            r.hold      = (rnd[29:28] == 2'b00);
            r.screen.x  = SCREEN_X;
            r.screen.y  = SCREEN_Y;
            r.exp_tri   = r.tri_data;
            model_item(r.tri_data, r.tri_valid, r.screen, r.subsample, r.exp_box, r.exp_valid);
            vectors.push_back(r);
        end
    endtask

    task automatic drive_row(input vec_row_t r);
        tri_in    = r.tri_data;
        tri_valid = r.tri_valid;
        screen    = r.screen;
        subsample = r.subsample;
        hold      = r.hold;
    endtask

    // Called at the falling edge after row i was sampled
    task automatic score_edge(input int i, input vec_row_t r);
        exp_entry_t e;
        box_t mb;
        logic mv;
        int errs_before;
        errs_before = err_count;
        if (r.hold) begin
            // The last item sits still at the outputs on a stalled edge
            if (have_last) begin
                check_box("box_out", box_out, last_out.b);
                check_tri("tri_out", tri_out, last_out.t);
                check_valid("box_valid", box_valid, last_out.v);
            end else if (box_valid !== 1'b0) begin
                $display("ERROR: box_valid high during hold before any item left");
                err_count++;
            end
            report_row(i, "hold", errs_before);
            return;
        end
        model_item(r.tri_data, r.tri_valid, r.screen, r.subsample, mb, mv);
        if (mb !== r.exp_box || mv !== r.exp_valid) begin
            $display("ERROR: reference model and table disagree on row %0d", i);
            err_count++;
        end
        e.idx = i;
        e.t   = r.exp_tri;
        e.b   = r.exp_box;
        e.v   = r.exp_valid;
        exp_q.push_back(e);
        // Oldest entry reaches the last stage on this edge
        if (exp_q.size() == PIPE_DEPTH) begin
            e = exp_q.pop_front();
            errs_before = err_count;
            check_box("box_out", box_out, e.b);
            check_tri("tri_out", tri_out, e.t);
            check_valid("box_valid", box_valid, e.v);
            last_out  = e;
            have_last = 1'b1;
            report_row(e.idx, "item", errs_before);
        end else if (box_valid !== 1'b0) begin
            $display("ERROR: box_valid high at row %0d with no item expected yet", i);
            err_count++;
        end
    endtask

    initial begin
        vec_row_t idle;
        lcg_state  = 32'h5589;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        have_last  = 1'b0;
        rows_ready = 1'b0;
        reset      = 1'b1;
        idle       = '0;
        idle.subsample = 4'b1000;
        idle.screen.x  = SCREEN_X;
        idle.screen.y  = SCREEN_Y;
        drive_row(idle);
        load_vectors();
        add_random_rows(RANDOM_ROWS);
        // Idle rows push the last real items out
        for (int n = 0; n < PIPE_DEPTH; n++) begin
            vectors.push_back(idle);
        end
        rows_ready = 1'b1;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_valid("box_valid", box_valid, 1'b0);
        end
        reset = 1'b0;
        for (int i = 0; i < vectors.size(); i++) begin
            drive_row(vectors[i]);
            @(negedge clk);
            score_edge(i, vectors[i]);
        end
        $display("Rows passed: %0d, rows failed: %0d, errors: %0d",
                 pass_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog at twice the nominal run length
    initial begin
        int limit_ns;
        wait (rows_ready);
        limit_ns = 2 * 10 * (vectors.size() + RESET_CYCLES);
        #(limit_ns);
        $display("Timeout: run still going after %0d ns", limit_ns);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: bbox_top.sv
`timescale 1ns/1ps

module bbox_top
    import rast_fixed_pkg::*;
    import rast_prim_pkg::*;
#(
    // Register stages between input and output
    parameter int PIPE_DEPTH = 3
)
(
    input  logic       clk,
    input  logic       reset,
    input  tri_t       tri_in,
    input  logic       tri_valid,
    input  point_t     screen,
    input  subsample_t subsample,
    input  logic       hold,
    output tri_t       tri_out,
    output box_t       box_out,
    output logic       box_valid
);

    // Raw per-axis extents of the incoming triangle
    box_t       raw_box;
    // Snapped and clipped item entering the pipeline
    bbox_item_t clip_item;
    // Item leaving the last stage
    bbox_item_t out_item;

    // Min and max per axis
    bbox_extent u_extent (
        .tri_in (tri_in),
        .box    (raw_box)
    );

    // Grid snap, screen clamp and reject
    bbox_grid_clip u_grid_clip (
        .tri_in    (tri_in),
        .tri_valid (tri_valid),
        .raw_box   (raw_box),
        .screen    (screen),
        .subsample (subsample),
        .item      (clip_item)
    );

    // Holdable register line
    bbox_delay #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) u_delay (
        .clk   (clk),
        .reset (reset),
        .hold  (hold),
        .d     (clip_item),
        .q     (out_item)
    );

    // Split the final item onto the output ports
    assign tri_out   = out_item.tri_data;
    assign box_out   = out_item.box;
    assign box_valid = out_item.valid;

endmodule

// File: bbox_delay.sv
`timescale 1ns/1ps

module bbox_delay
    import rast_prim_pkg::*;
#(
    // Number of register stages, at least one
    parameter int PIPE_DEPTH = 3
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       hold,
    input  bbox_item_t d,
    output bbox_item_t q
);

    // Register line, stage 0 takes the input
    bbox_item_t stage [PIPE_DEPTH];

    always_ff @(posedge clk) begin
        // All stages advance together, never collapsing bubbles
        if (!hold) begin
            stage[0] <= d;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
        // Reset wins over hold and kills only the valid flags
        // Box and triangle fields are left as they are
        if (reset) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                stage[i].valid <= 1'b0;
            end
        end
    end

    // Last stage feeds the outputs
    assign q = stage[PIPE_DEPTH-1];

endmodule

// File: bbox_grid_clip.sv
`timescale 1ns/1ps

module bbox_grid_clip
    import rast_fixed_pkg::*;
    import rast_prim_pkg::*;
(
    input  tri_t       tri_in,
    input  logic       tri_valid,
    input  box_t       raw_box,
    input  point_t     screen,
    input  subsample_t subsample,
    output bbox_item_t item
);

    // Code bit on the fraction, one bit set, half the grid step
    frac_t step;
    // Fraction bits kept after flooring
    frac_t mask;
    // Corners floored to the sample grid
    box_t  snap_box;
    // Corners after clamping to the screen
    box_t  clip_box;
    // Box overlaps the screen at all
    logic  on_screen;

    // Floor one coordinate to the grid
    // Integer part passes and masked fraction bits are cleared
    // Two's complement makes this a true floor for negative values too
    function automatic coord_t floor_grid(coord_t c, frac_t m);
        coord_t r;
        r = c;
        r[RADIX-1:0] = c[RADIX-1:0] & m;
        return r;
    endfunction

    // Pull a coordinate left of or below the origin back to zero
    function automatic coord_t clamp_low(coord_t c);
        return (c < 0) ? '0 : c;
    endfunction

    // Pull a coordinate past the screen edge back to the edge
    function automatic coord_t clamp_high(coord_t c, coord_t lim);
        return (c > lim) ? lim : c;
    endfunction

    // Code bits land on fraction bits RADIX-1 down to RADIX-4
    assign step = {subsample, {(RADIX-4){1'b0}}};

    // Clear the code bit and every bit under it
    // 1000 gives a step of one pixel, 0001 an eighth of a pixel
    assign mask = ~(step | (step - frac_t'(1)));

    // Snap all four corner coordinates
    always_comb begin
        snap_box.ll.x = floor_grid(raw_box.ll.x, mask);
        snap_box.ll.y = floor_grid(raw_box.ll.y, mask);
        snap_box.ur.x = floor_grid(raw_box.ur.x, mask);
        snap_box.ur.y = floor_grid(raw_box.ur.y, mask);
    end

    // Clip to the visible screen
    always_comb begin
        // Lower left never goes below the origin
        clip_box.ll.x = clamp_low(snap_box.ll.x);
        clip_box.ll.y = clamp_low(snap_box.ll.y);
        // Upper right never goes past the screen size
        clip_box.ur.x = clamp_high(snap_box.ur.x, screen.x);
        clip_box.ur.y = clamp_high(snap_box.ur.y, screen.y);
    end

    // Reject boxes lying wholly off screen
    // A box right of or above the screen keeps ll past the edge
    // A box left of or below the screen keeps ur under zero
    assign on_screen = (clip_box.ll.x <= screen.x)
                    && (clip_box.ll.y <= screen.y)
                    && (clip_box.ur.x >= 0)
                    && (clip_box.ur.y >= 0);

    // Pack one pipeline item
    always_comb begin
        item.tri_data = tri_in;
        item.box      = clip_box;
        // Invalid input never turns valid here
        item.valid    = tri_valid && on_screen;
    end

endmodule

// File: bbox_extent.sv
`timescale 1ns/1ps

module bbox_extent
    import rast_fixed_pkg::*;
    import rast_prim_pkg::*;
(
    input  tri_t tri_in,
    output box_t box
);

    // One-hot vertex select, bit i picks vertex i
    typedef logic [VERTS-1:0] vsel_t;

    // Select of the smallest of three values
    // Ties go to the later vertex
    function automatic vsel_t min_sel(coord_t a, coord_t b, coord_t c);
        if (a < b) begin
            return (a < c) ? 3'b001 : 3'b100;
        end
        return (b < c) ? 3'b010 : 3'b100;
    endfunction

    // Select of the largest of three values
    // Ties go to the lower vertex index
    function automatic vsel_t max_sel(coord_t a, coord_t b, coord_t c);
        if (a >= b) begin
            return (a >= c) ? 3'b001 : 3'b100;
        end
        return (b >= c) ? 3'b010 : 3'b100;
    endfunction

    // Mux of one coordinate by a one-hot select
    function automatic coord_t pick(vsel_t sel, coord_t a, coord_t b, coord_t c);
        case (sel)
            3'b001:  return a;
            3'b010:  return b;
            3'b100:  return c;
            // Unreachable, selects are always one-hot
            default: return a;
        endcase
    endfunction

    // Per-corner selects
    vsel_t sel_ll_x;
    vsel_t sel_ll_y;
    vsel_t sel_ur_x;
    vsel_t sel_ur_y;

    always_comb begin
        // Lower left takes the minimum on each axis
        sel_ll_x = min_sel(tri_in[0].x, tri_in[1].x, tri_in[2].x);
        sel_ll_y = min_sel(tri_in[0].y, tri_in[1].y, tri_in[2].y);
        // Upper right takes the maximum on each axis
        sel_ur_x = max_sel(tri_in[0].x, tri_in[1].x, tri_in[2].x);
        sel_ur_y = max_sel(tri_in[0].y, tri_in[1].y, tri_in[2].y);
    end

    always_comb begin
        // Route the chosen vertex coordinate to each corner
        box.ll.x = pick(sel_ll_x, tri_in[0].x, tri_in[1].x, tri_in[2].x);
        box.ll.y = pick(sel_ll_y, tri_in[0].y, tri_in[1].y, tri_in[2].y);
        box.ur.x = pick(sel_ur_x, tri_in[0].x, tri_in[1].x, tri_in[2].x);
        box.ur.y = pick(sel_ur_y, tri_in[0].y, tri_in[1].y, tri_in[2].y);
    end

endmodule

// File: rast_prim_pkg.sv
package rast_prim_pkg;

    // Primitive shapes handled by the bounding box stage
    import rast_fixed_pkg::*;

    // Vertices per triangle
    localparam int VERTS = 3;

    // Triangle as a packed array of vertices
    // Index 0 is vertex a, index 2 is vertex c
    // 3 x 48 = 144 bits
    typedef point_t [VERTS-1:0] tri_t;

    // Axis-aligned box
    // ll is the lower left corner, ur the upper right one
    // 2 x 48 = 96 bits
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    // One-hot multisample code
    // 1000 one sample per pixel
    // 0100 half-pixel grid, four samples per pixel
    // 0010 quarter-pixel grid, sixteen samples per pixel
    // 0001 eighth-pixel grid, sixty-four samples per pixel
    typedef logic [3:0] subsample_t;

    // Everything that travels down the pipeline for one triangle
    // The box and triangle ride along even when valid is low
    // 144 + 96 + 1 = 241 bits
    typedef struct packed {
        tri_t tri_data;
        box_t box;
        logic valid;
    } bbox_item_t;

endpackage

// File: rast_fixed_pkg.sv
package rast_fixed_pkg;

    // Signed fixed-point number format shared by every coordinate
    // in the raster front end

    // Total bits of one coordinate
    localparam int SIGFIG = 24;

    // Bits below the binary point
    localparam int RADIX = 10;

    // Upper SIGFIG-RADIX bits hold the integer part in two's complement
    // Lower RADIX bits hold the fraction of a pixel
    typedef logic signed [SIGFIG-1:0] coord_t;

    // Fraction field on its own
    // Used for sample grid masks and steps
    typedef logic [RADIX-1:0] frac_t;

    // A position on the screen plane
    // x is the horizontal axis and y the vertical one
    // 2 x 24 = 48 bits
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

endpackage
